//--- vlog.f
hw/lcd_pkg.sv
hw/lcd_spi_shifter.sv
hw/lcd_sprite_rom.sv
hw/lcd_bar_gen.sv
hw/lcd_sequencer.sv
hw/lcd_display_top.sv
verif/tb_lcd_display.sv

//--- Makefile
# Verilator build and run for the lcd display driver

VERILATOR ?= verilator
TOP       ?= tb_lcd_display
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= *** FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/lcd_golden.txt
// per test: kind, draw code, levels (hunger sleep fun mood health), entry count (hex)
// kind 0 reset, 1 listed stream, 2 bars from levels, 3 bars from random levels, f end
// entry: dc digit, three digit repeat count, byte
0 0 00000 05
000121 000190 000120 00010c 11f800
1 3 00000 09 // cross
00019a 000142 10013c 100124 1001e7 100281 1001e7 100124 10013c
1 7 00000 05 // test pattern
000183 000142 100204 10017c 100204
1 8 00000 0b // happy face
0001a5 000143 1001de 100208 1001de
0001a5 000144 100112 100114 100134 100152
1 a 00000 0b // sad face
0001a5 000143 1001de 100208 1001de
0001a5 000144 100114 100112 100132 100154
2 1 0359f 00 // empty, partial, full and clamped bars
1 7 00000 05
000183 000142 100204 10017c 100204
3 1 00000 00
1 1 00000 00 // same code again, nothing sent
1 2 00000 00 // unknown code
1 8 00000 0b
0001a5 000143 1001de 100208 1001de
0001a5 000144 100112 100114 100134 100152
3 1 00000 00
f

//--- verif/tb_lcd_display.sv
/* lcd display testbench
   replays the golden stimulus against the driver and checks the serial byte stream */
`timescale 1ns/1ps

module tb_lcd_display;
	import lcd_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int GOLD_WORDS = 256;
	localparam logic [7:0] POS_X [5] = '{8'h09, 8'h27, 8'h42, 8'h15, 8'h3c};
	localparam logic [7:0] POS_Y [5] = '{8'h00, 8'h00, 8'h00, 8'h01, 8'h01};

	logic       clock;
	logic       rst_n;
	draw_code_t draw;
	level_t     hunger;
	level_t     sleep;
	level_t     fun;
	level_t     mood;
	level_t     health;
	logic       done;
	logic       mosi;
	logic       sclk;
	logic       sce;
	logic       dc;
	logic       lcd_rst;

	logic [23:0] gold_mem [0:GOLD_WORDS-1];
	logic [8:0]  got_q [$];  // {dc, byte} seen on the wire
	logic [8:0]  exp_q [$];
	logic [7:0]  rx_byte;
	int          bit_cnt;
	int          err_count;
	int          limit_cycles;
	integer      seed;

	initial clock = 1'b0;
	always #(CLK_PERIOD / 2) clock = ~clock;

	lcd_display_top DUT (
		.clock   (clock),
		.rst_n   (rst_n),
		.draw    (draw),
		.hunger  (hunger),
		.sleep   (sleep),
		.fun     (fun),
		.mood    (mood),
		.health  (health),
		.done    (done),
		.mosi    (mosi),
		.sclk    (sclk),
		.sce     (sce),
		.dc      (dc),
		.lcd_rst (lcd_rst)
	);

	// ----------------------------------------
	// serial capture, panel side view
	always @(posedge sclk or posedge sce) begin
		if (sce) begin
			bit_cnt = 0;
		end else begin
			rx_byte = {rx_byte[6:0], mosi};  // msb first
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 8) begin
				got_q.push_back({dc, rx_byte});
				bit_cnt = 0;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	function automatic void load_entries(input int p, input int n);
		logic [23:0] w;
		for (int j = 0; j < n; j++) begin
			w = gold_mem[p + j];
			repeat (int'(w[19:8])) begin
				exp_q.push_back({w[20], w[7:0]});
			end
		end
	endfunction

	function automatic void add_bars(input logic [19:0] levels);
		int         units;
		logic [3:0] lvl;
		for (int i = 0; i < 5; i++) begin
			lvl   = levels[19 - 4 * i -: 4];
			units = (int'(lvl) > BAR_MAX_UNITS) ? BAR_MAX_UNITS : int'(lvl);
			exp_q.push_back({1'b0, 8'h80 + POS_X[i]});
			exp_q.push_back({1'b0, 8'h40 + POS_Y[i]});
			for (int c = 0; c < BAR_COLUMNS; c++) begin
				if (c < 3 * units && c % 3 != 2) begin
					exp_q.push_back({1'b1, 8'h7e});
				end else begin
					exp_q.push_back({1'b1, 8'h00});  // gap column or empty part
				end
			end
		end
	endfunction

	// cycles for every expected byte, doubled, plus room for reset and waits
	function automatic int count_limit();
		int p;
		int n;
		int bytes;
		int tests;
		p     = 0;
		bytes = 0;
		tests = 0;
		while (p <= GOLD_WORDS - 4 && gold_mem[p] !== 24'hf && !$isunknown(gold_mem[p])) begin
			n = int'(gold_mem[p + 3]);
			if (gold_mem[p][3:0] inside {4'h2, 4'h3}) begin
				bytes += 5 * (2 + BAR_COLUMNS);
			end
			for (int j = 0; j < n; j++) begin
				bytes += int'(gold_mem[p + 4 + j][19:8]);
			end
			p += 4 + n;
			tests++;
		end
		return 2 * bytes * (1 + 16 * SCLK_HALF) + 50 * tests + 100;
	endfunction

	task automatic compare_streams();
		int n;
		int errs_before;
		check_value("byte count", 32'(got_q.size()), 32'(exp_q.size()));
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			errs_before = err_count;
			check_value($sformatf("dc/byte %0d", i), 32'(got_q[i]), 32'(exp_q[i]));
			if (err_count != errs_before) begin
				break;
			end
		end
	endtask

	task automatic wait_idle();
		wait (done === 1'b1);
		@(negedge clock);
		wait (sce === 1'b1);  // last byte still shifting after done
		@(negedge clock);
	endtask

	task automatic run_reset();
		@(negedge clock);
		check_value("done", 32'(done), 32'd0);
		check_value("sclk", 32'(sclk), 32'd0);
		check_value("mosi", 32'(mosi), 32'd0);
		check_value("sce", 32'(sce), 32'd1);
		check_value("dc", 32'(dc), 32'd1);
		check_value("lcd_rst", 32'(lcd_rst), 32'd0);
		repeat (4) @(posedge clock);
		#1;
		rst_n = 1'b1;
		@(negedge clock);
		check_value("lcd_rst", 32'(lcd_rst), 32'd0);
		wait_idle();
		check_value("lcd_rst", 32'(lcd_rst), 32'd1);
	endtask

	task automatic run_draw(input draw_code_t code, input logic [19:0] levels);
		@(posedge clock);
		#1;
		draw   = code;
		hunger = levels[19:16];
		sleep  = levels[15:12];
		fun    = levels[11:8];
		mood   = levels[7:4];
		health = levels[3:0];
		// a draw starts within 2 cycles
		for (int i = 0; i < 3; i++) begin
			@(negedge clock);
			if (exp_q.size() == 0) begin
				check_value("done", 32'(done), 32'd1);
			end else if (i == 1) begin
				check_value("done", 32'(done), 32'd0);
			end
		end
		wait_idle();
	endtask

	// ----------------------------------------
	// watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int          ptr;
		int          n;
		int          test_no;
		int          failed;
		int          errs_before;
		logic [3:0]  kind;
		draw_code_t  code;
		logic [19:0] levels;

		rst_n     = 1'b0;
		draw      = '0;
		hunger    = '0;
		sleep     = '0;
		fun       = '0;
		mood      = '0;
		health    = '0;
		err_count = 0;
		seed      = 32'hd89ef695;
		$readmemh("verif/lcd_golden.txt", gold_mem);
		limit_cycles = count_limit();

		ptr     = 0;
		test_no = 0;
		failed  = 0;
		while (ptr <= GOLD_WORDS - 4 && gold_mem[ptr] !== 24'hf) begin
			if ($isunknown(gold_mem[ptr])) begin
				break;
			end
			kind   = gold_mem[ptr][3:0];
			code   = gold_mem[ptr + 1][3:0];
			levels = gold_mem[ptr + 2][19:0];
			n      = int'(gold_mem[ptr + 3]);
			ptr += 4;
			got_q.delete();
			exp_q.delete();
			errs_before = err_count;
			load_entries(ptr, n);
			ptr += n;
			if (kind == 4'h3) begin
				levels = 20'($random(seed));
			end
			if (kind == 4'h2 || kind == 4'h3) begin
				add_bars(levels);
			end
			if (kind == 4'h0) begin
				run_reset();
			end else begin
				run_draw(code, levels);
			end
			compare_streams();
			test_no++;
			if (err_count != errs_before) begin
				failed++;
			end
			$display("test %0d: kind %0h code %0d levels %h, %0d bytes, %s", test_no, kind,
				code, levels, got_q.size(), (err_count == errs_before) ? "ok" : "mismatch");
		end
		if (ptr > GOLD_WORDS - 4 || gold_mem[ptr] !== 24'hf) begin
			$display("golden file has no end marker at word %0d", ptr);
			err_count++;
		end
		if (test_no == 0) begin
			$display("golden file holds no tests");
			err_count++;
		end

		$display("%0d tests, %0d failed, %0d errors", test_no, failed, err_count);
		if (err_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- hw/lcd_display_top.sv
/* lcd display top
   sequencer, sprite table, bar generator and serial shifter */
`timescale 1ns/1ps

module lcd_display_top (
	input  logic                clock,
	input  logic                rst_n,
	input  lcd_pkg::draw_code_t draw,
	input  lcd_pkg::level_t     hunger,
	input  lcd_pkg::level_t     sleep,
	input  lcd_pkg::level_t     fun,
	input  lcd_pkg::level_t     mood,
	input  lcd_pkg::level_t     health,
	output logic                done,
	output logic                mosi,
	output logic                sclk,
	output logic                sce,
	output logic                dc,
	output logic                lcd_rst
);
	import lcd_pkg::*;

	logic       tx_start;
	lcd_byte_t  tx_byte;
	logic       tx_dc;
	logic       tx_next;
	draw_code_t sprite_code;
	logic [4:0] sprite_step;
	lcd_byte_t  sprite_byte;
	logic       sprite_dc;
	logic       sprite_last;
	logic       bar_begin;
	logic       bar_advance;
	lcd_byte_t  bar_byte;
	logic       bar_dc;
	logic       bar_last;

	lcd_sequencer u_sequencer (
		.clock       (clock),
		.rst_n       (rst_n),
		.draw        (draw),
		.done        (done),
		.lcd_rst     (lcd_rst),
		.tx_start    (tx_start),
		.tx_byte     (tx_byte),
		.tx_dc       (tx_dc),
		.tx_next     (tx_next),
		.sprite_code (sprite_code),
		.sprite_step (sprite_step),
		.sprite_byte (sprite_byte),
		.sprite_dc   (sprite_dc),
		.sprite_last (sprite_last),
		.bar_begin   (bar_begin),
		.bar_advance (bar_advance),
		.bar_byte    (bar_byte),
		.bar_dc      (bar_dc),
		.bar_last    (bar_last)
	);

	lcd_sprite_rom u_sprite_rom (
		.sprite_code (sprite_code),
		.sprite_step (sprite_step),
		.sprite_byte (sprite_byte),
		.sprite_dc   (sprite_dc),
		.sprite_last (sprite_last)
	);

	lcd_bar_gen u_bar_gen (
		.clock       (clock),
		.rst_n       (rst_n),
		.bar_begin   (bar_begin),
		.bar_advance (bar_advance),
		.hunger      (hunger),
		.sleep       (sleep),
		.fun         (fun),
		.mood        (mood),
		.health      (health),
		.bar_byte    (bar_byte),
		.bar_dc      (bar_dc),
		.bar_last    (bar_last)
	);

	lcd_spi_shifter u_shifter (
		.clock    (clock),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_dc    (tx_dc),
		.tx_next  (tx_next),
		.mosi     (mosi),
		.sclk     (sclk),
		.sce      (sce),
		.dc       (dc)
	);

endmodule

//--- hw/lcd_sequencer.sv
/* lcd sequencer
   panel reset, configuration and clear, then draws on each new draw code */
`timescale 1ns/1ps

module lcd_sequencer (
	input  logic                clock,
	input  logic                rst_n,
	input  lcd_pkg::draw_code_t draw,
	output logic                done,
	output logic                lcd_rst,
	output logic                tx_start,
	output lcd_pkg::lcd_byte_t  tx_byte,
	output logic                tx_dc,
	input  logic                tx_next,
	output lcd_pkg::draw_code_t sprite_code,
	output logic [4:0]          sprite_step,
	input  lcd_pkg::lcd_byte_t  sprite_byte,
	input  logic                sprite_dc,
	input  logic                sprite_last,
	output logic                bar_begin,
	output logic                bar_advance,
	input  lcd_pkg::lcd_byte_t  bar_byte,
	input  logic                bar_dc,
	input  logic                bar_last
);
	import lcd_pkg::*;

	localparam int RST_W = $clog2(PANEL_RESET_CYCLES);
	localparam int CLR_W = $clog2(CLEAR_BYTES);

	typedef enum logic [2:0] {
		S_RESET,
		S_CONFIG,
		S_CLEAR,
		S_STANDBY,
		S_SPRITE,
		S_BARS
	} state_t;

	state_t     state;
	logic [RST_W-1:0] rst_cnt;
	logic [1:0]       cfg_idx;
	logic [CLR_W-1:0] clr_cnt;
	draw_code_t       last_code;  // last handled code
	logic             code_changed;
	logic             is_sprite;

	assign code_changed = (state == S_STANDBY) && (draw != last_code);
	assign is_sprite    = draw inside {DRAW_CROSS, DRAW_TEST, DRAW_HAPPY, DRAW_SAD};
	assign bar_begin    = code_changed && (draw == DRAW_BARS);
	assign bar_advance  = tx_next && (state == S_BARS);
	assign tx_start     = state inside {S_CONFIG, S_CLEAR, S_SPRITE, S_BARS};

	// ----------------------------------------
	// byte source select
	always_comb begin
		tx_byte = 8'h00;
		tx_dc   = 1'b1;
		case (state)
			S_CONFIG: begin
				tx_dc = 1'b0;
				case (cfg_idx)
					2'd0:    tx_byte = CMD_EXTENDED;
					2'd1:    tx_byte = CMD_VOP;
					2'd2:    tx_byte = CMD_BASIC;
					default: tx_byte = CMD_NORMAL;
				endcase
			end
			S_SPRITE: begin
				tx_byte = sprite_byte;
				tx_dc   = sprite_dc;
			end
			S_BARS: begin
				tx_byte = bar_byte;
				tx_dc   = bar_dc;
			end
			default: begin
				tx_byte = 8'h00;  // clear writes zero data
			end
		endcase
	end

	// ----------------------------------------
	// control FSM
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_RESET;
			rst_cnt     <= '0;
			cfg_idx     <= '0;
			clr_cnt     <= '0;
			last_code   <= '0;
			sprite_code <= '0;
			sprite_step <= '0;
			done        <= 1'b0;
			lcd_rst     <= 1'b0;
		end else begin
			case (state)
				S_RESET: begin
					if (rst_cnt == RST_W'(PANEL_RESET_CYCLES - 1)) begin
						lcd_rst <= 1'b1;  // release panel
						state   <= S_CONFIG;
					end else begin
						rst_cnt <= rst_cnt + RST_W'(1);
					end
				end
				S_CONFIG: begin
					if (tx_next) begin
						cfg_idx <= cfg_idx + 2'd1;
						if (cfg_idx == 2'd3) begin
							state <= S_CLEAR;
						end
					end
				end
				S_CLEAR: begin
					if (tx_next) begin
						clr_cnt <= clr_cnt + CLR_W'(1);
						if (clr_cnt == CLR_W'(CLEAR_BYTES - 1)) begin
							state <= S_STANDBY;
							done  <= 1'b1;
						end
					end
				end
				S_STANDBY: begin
					if (code_changed) begin
						last_code <= draw;  // unknown codes are only recorded
						if (draw == DRAW_BARS) begin
							state <= S_BARS;
							done  <= 1'b0;
						end else if (is_sprite) begin
							sprite_code <= draw;
							sprite_step <= '0;
							state       <= S_SPRITE;
							done        <= 1'b0;
						end
					end
				end
				S_SPRITE: begin
					if (tx_next) begin
						if (sprite_last) begin
							state <= S_STANDBY;
							done  <= 1'b1;
						end else begin
							sprite_step <= sprite_step + 5'd1;
						end
					end
				end
				S_BARS: begin
					if (tx_next && bar_last) begin
						state <= S_STANDBY;
						done  <= 1'b1;
					end
				end
				default: begin
					state <= S_RESET;
				end
			endcase
		end
	end

endmodule

//--- hw/lcd_bar_gen.sv
/* status bar generator
   byte stream for the five level bars, each a position pair then columns */
`timescale 1ns/1ps

module lcd_bar_gen (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               bar_begin,
	input  logic               bar_advance,
	input  lcd_pkg::level_t    hunger,
	input  lcd_pkg::level_t    sleep,
	input  lcd_pkg::level_t    fun,
	input  lcd_pkg::level_t    mood,
	input  lcd_pkg::level_t    health,
	output lcd_pkg::lcd_byte_t bar_byte,
	output logic               bar_dc,
	output logic               bar_last
);
	import lcd_pkg::*;

	localparam int POS_LAST = BAR_COLUMNS + 1;

	level_t     units_q [5];  // clamped levels
	logic [2:0] bar_idx;
	logic [4:0] pos;    // 0 x cmd, 1 row cmd, then columns
	logic [1:0] phase;  // column inside a unit
	logic [2:0] unit;
	level_t     cur_units;

	function automatic level_t clamp_level(input level_t lvl);
		return (lvl > level_t'(BAR_MAX_UNITS)) ? level_t'(BAR_MAX_UNITS) : lvl;
	endfunction

	always_ff @(posedge clock) begin
		if (bar_begin) begin
			units_q[0] <= clamp_level(hunger);
			units_q[1] <= clamp_level(sleep);
			units_q[2] <= clamp_level(fun);
			units_q[3] <= clamp_level(mood);
			units_q[4] <= clamp_level(health);
		end
	end

	// ----------------------------------------
	// stream position
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			bar_idx <= '0;
			pos     <= '0;
			phase   <= '0;
			unit    <= '0;
		end else if (bar_begin) begin
			bar_idx <= '0;
			pos     <= '0;
			phase   <= '0;
			unit    <= '0;
		end else if (bar_advance) begin
			if (pos == 5'(POS_LAST)) begin
				pos     <= '0;
				phase   <= '0;
				unit    <= '0;
				bar_idx <= (bar_idx == 3'd4) ? 3'd0 : bar_idx + 3'd1;
			end else begin
				pos <= pos + 5'd1;
				if (pos > 5'd1) begin
					if (phase == 2'd2) begin
						phase <= '0;
						unit  <= unit + 3'd1;
					end else begin
						phase <= phase + 2'd1;
					end
				end
			end
		end
	end

	// ----------------------------------------
	// byte output
	assign cur_units = units_q[bar_idx];

	always_comb begin
		if (pos == 5'd0) begin
			bar_byte = 8'h80 + BAR_X[bar_idx];
		end else if (pos == 5'd1) begin
			bar_byte = 8'h40 + BAR_Y[bar_idx];
		end else if (({1'b0, unit} < cur_units) && (phase != 2'd2)) begin
			bar_byte = 8'h7e;  // filled column
		end else begin
			bar_byte = 8'h00;
		end
	end

	assign bar_dc   = (pos > 5'd1);
	assign bar_last = (bar_idx == 3'd4) && (pos == 5'(POS_LAST));

endmodule

//--- hw/lcd_sprite_rom.sv
/* lcd sprite table
   fixed byte streams for the cross, test pattern and face sprites */
`timescale 1ns/1ps

module lcd_sprite_rom (
	input  lcd_pkg::draw_code_t sprite_code,
	input  logic [4:0]          sprite_step,
	output lcd_pkg::lcd_byte_t  sprite_byte,
	output logic                sprite_dc,
	output logic                sprite_last
);
	import lcd_pkg::*;

	logic sad;

	assign sad = (sprite_code == DRAW_SAD);

	always_comb begin
		sprite_byte = 8'h00;
		sprite_dc   = 1'b1;
		sprite_last = 1'b0;
		case (sprite_code)
			DRAW_CROSS: begin
				case (sprite_step)
					5'd0:       sprite_byte = 8'h9a;
					5'd1:       sprite_byte = 8'h42;
					5'd2, 5'd9: sprite_byte = 8'h3c;
					5'd3, 5'd8: sprite_byte = 8'h24;
					5'd4, 5'd7: sprite_byte = 8'he7;
					5'd5, 5'd6: sprite_byte = 8'h81;
					default:    sprite_byte = 8'h00;
				endcase
				sprite_dc   = (sprite_step > 5'd1);
				sprite_last = (sprite_step == 5'd9);
			end
			DRAW_TEST: begin
				case (sprite_step)
					5'd0:    sprite_byte = 8'h83;
					5'd1:    sprite_byte = 8'h42;
					5'd4:    sprite_byte = 8'h7c;  // stem of the t
					default: sprite_byte = 8'h04;
				endcase
				sprite_dc   = (sprite_step > 5'd1);
				sprite_last = (sprite_step == 5'd6);
			end
			DRAW_HAPPY, DRAW_SAD: begin
				case (sprite_step)
					5'd0, 5'd6: sprite_byte = 8'ha5;
					5'd1:       sprite_byte = 8'h43;  // eyes row
					5'd2, 5'd5: sprite_byte = 8'hde;
					5'd3, 5'd4: sprite_byte = 8'h08;
					5'd7:       sprite_byte = 8'h44;  // mouth row
					5'd8:       sprite_byte = sad ? 8'h14 : 8'h12;
					5'd9:       sprite_byte = sad ? 8'h12 : 8'h14;
					5'd10:      sprite_byte = sad ? 8'h32 : 8'h34;
					5'd11:      sprite_byte = sad ? 8'h54 : 8'h52;
					default:    sprite_byte = 8'h00;
				endcase
				sprite_dc   = !(sprite_step inside {5'd0, 5'd1, 5'd6, 5'd7});
				sprite_last = (sprite_step == 5'd11);
			end
			default: begin
				sprite_last = 1'b1;  // unknown code, nothing to draw
			end
		endcase
	end

endmodule

//--- hw/lcd_spi_shifter.sv
/* lcd serial shifter
   sends one byte msb first with a divided serial clock, chip enable
   and data/command line */
`timescale 1ns/1ps

module lcd_spi_shifter (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               tx_start,
	input  lcd_pkg::lcd_byte_t tx_byte,
	input  logic               tx_dc,
	output logic               tx_next,
	output logic               mosi,
	output logic               sclk,
	output logic               sce,
	output logic               dc
);
	import lcd_pkg::*;

	localparam int DIV_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       half_cnt;  // 16 half periods per byte
	lcd_byte_t        shift_q;

	assign tx_next = tx_start && !busy;  // byte taken this cycle
	assign mosi    = shift_q[7];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			div_cnt  <= '0;
			half_cnt <= '0;
			shift_q  <= '0;
			sclk     <= 1'b0;
			sce      <= 1'b1;
			dc       <= 1'b1;
		end else if (tx_next) begin
			busy     <= 1'b1;
			div_cnt  <= '0;
			half_cnt <= '0;
			shift_q  <= tx_byte;
			dc       <= tx_dc;
			sce      <= 1'b0;
			sclk     <= 1'b0;
		end else if (busy) begin
			if (div_cnt == DIV_W'(SCLK_HALF - 1)) begin
				div_cnt  <= '0;
				half_cnt <= half_cnt + 4'd1;
				if (half_cnt == 4'd15) begin
					busy <= 1'b0;  // last bit done
					sce  <= 1'b1;
					sclk <= 1'b0;
				end else begin
					sclk <= ~sclk;
				end
				if (sclk) begin
					shift_q <= {shift_q[6:0], 1'b0};  // next bit on falling edge
				end
			end else begin
				div_cnt <= div_cnt + DIV_W'(1);
			end
		end
	end

endmodule

//--- hw/lcd_pkg.sv
/* lcd display package
   panel constants, draw codes and byte types for the 84x48 serial lcd driver */
package lcd_pkg;

	typedef logic [7:0] lcd_byte_t;
	typedef logic [3:0] level_t;
	typedef logic [3:0] draw_code_t;

	// ----------------------------------------
	// timing
	localparam int SCLK_HALF          = 4;    // clock cycles per half sclk
	localparam int PANEL_RESET_CYCLES = 8;
	localparam int CLEAR_BYTES        = 504;  // 84 columns x 6 rows

	// ----------------------------------------
	// configuration commands
	localparam lcd_byte_t CMD_EXTENDED = 8'h21;  // extended instruction set
	localparam lcd_byte_t CMD_VOP      = 8'h90;  // contrast
	localparam lcd_byte_t CMD_BASIC    = 8'h20;
	localparam lcd_byte_t CMD_NORMAL   = 8'h0c;  // normal display mode

	// ----------------------------------------
	// draw codes
	localparam draw_code_t DRAW_BARS  = 4'd1;
	localparam draw_code_t DRAW_CROSS = 4'd3;
	localparam draw_code_t DRAW_TEST  = 4'd7;
	localparam draw_code_t DRAW_HAPPY = 4'd8;
	localparam draw_code_t DRAW_SAD   = 4'd10;

	// ----------------------------------------
	// status bars
	localparam int BAR_COLUMNS   = 16;
	localparam int BAR_MAX_UNITS = 5;

	// order: hunger, sleep, fun, mood, health
	localparam lcd_byte_t BAR_X [5] = '{8'h09, 8'h27, 8'h42, 8'h15, 8'h3c};
	localparam lcd_byte_t BAR_Y [5] = '{8'h00, 8'h00, 8'h00, 8'h01, 8'h01};

endpackage
